// ==== include/adpll_config.svh ====
`ifndef ADPLL_CONFIG_SVH
`define ADPLL_CONFIG_SVH

////////////////////////////////////////
// Word widths
////////////////////////////////////////
`define ADPLL_FCWW 26
`define ADPLL_ACCW 27
`define ADPLL_INTW 12
`define ADPLL_FRAW 14
`define ADPLL_TDCW 12
`define ADPLL_OTW_SHIFT 7
`define ADPLL_OTWW (`ADPLL_ACCW - `ADPLL_FRAW)

// Power-up sequence, counted in enabled cycles
`define ADPLL_PU_TDC 16
`define ADPLL_PU_INJ 48
`define ADPLL_PU_DONE 112

// Lock decisions
`define ADPLL_LOCK_TIME 480
`define ADPLL_LOCK_REPEAT 15
`define ADPLL_LOCK_REPEAT_COARSE 8

// Capacitor bank limits
`define ADPLL_L_MAX 12
`define ADPLL_L_MIN (-13)
`define ADPLL_MS_MAX 127
`define ADPLL_MS_MIN (-128)

`endif

// ==== project.f ====
+incdir+include
src/adpll_pkg.sv
src/phase_accumulator.sv
src/loop_filter.sv
src/dco_word_steering.sv
src/lock_detector.sv
src/acquisition_fsm.sv
src/adpll_ctrl.sv
tests/tb_adpll_ctrl.sv

// ==== src/acquisition_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adpll_config.svh"

module acquisition_fsm import adpll_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   en,
   input  logic [`ADPLL_FCWW-1:0] fcw,
   input  adpll_mode_t            mode,
   input  logic                   lock,
   input  otw_t                   lock_word,
   input  otw_t                   otw_sat,
   input  logic [3:0]             alpha_l,
   input  logic [3:0]             alpha_m,
   input  logic [3:0]             alpha_s_rx,
   input  logic [3:0]             alpha_s_tx,
   input  logic [3:0]             beta,
   input  logic [2:0]             lambda_rx,
   input  logic [2:0]             lambda_tx,
   input  logic [1:0]             iir_n_rx,
   input  logic [1:0]             iir_n_tx,
   output acq_state_t             state,
   output logic                   acc_clear,
   output logic                   lock_clear,
   output logic                   lock_en,
   output logic                   coarse,
   output logic [3:0]             alpha,
   output logic [2:0]             lambda,
   output logic [1:0]             iir_n,
   output logic                   integral_en,
   output l_word_t                hold_l,
   output ms_word_t               hold_m,
   output ms_word_t               hold_s,
   output logic                   dco_pd_state,
   output logic                   tdc_pd_state,
   output logic                   tdc_pd_inj_state,
   output logic                   channel_lock,
   output logic                   channel_sat
);

   logic [`ADPLL_FCWW-1:0] fcw_last;
   adpll_mode_t            mode_last;
   logic [8:0]             time_count;
   logic                   lock_seen;

   // Lock is stale while the detector clear is still in flight
   assign lock_seen = lock && !lock_clear;
   assign coarse    = (state == ST_COARSE);

   ////////////////////////////////////////
   // Loop gains per step
   ////////////////////////////////////////
   always_comb begin
      alpha  = alpha_s_rx;
      lambda = lambda_rx;
      iir_n  = 2'd0;
      case (state)
         ST_COARSE: alpha = alpha_l;
         ST_MEDIUM: alpha = alpha_m;
         ST_FINE: begin
            if (mode == MODE_TX) begin
               alpha  = alpha_s_tx;
               lambda = lambda_tx;
               iir_n  = iir_n_tx;
            end else begin
               iir_n = iir_n_rx;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state            <= ST_IDLE;
         fcw_last         <= fcw;
         mode_last        <= mode;
         time_count       <= '0;
         acc_clear        <= 1'b0;
         lock_clear       <= 1'b0;
         lock_en          <= 1'b0;
         integral_en      <= 1'b0;
         hold_l           <= '0;
         hold_m           <= '0;
         hold_s           <= '0;
         dco_pd_state     <= 1'b1;
         tdc_pd_state     <= 1'b1;
         tdc_pd_inj_state <= 1'b1;
         channel_lock     <= 1'b0;
         channel_sat      <= 1'b0;
      end else if (en) begin
         fcw_last  <= fcw;
         mode_last <= mode;
         // New channel or mode restarts acquisition
         if (fcw != fcw_last || mode != mode_last) begin
            state <= ST_IDLE;
         end else begin
            case (state)
               ST_IDLE: begin
                  time_count   <= '0;
                  acc_clear    <= 1'b0;
                  lock_clear   <= 1'b1;
                  lock_en      <= 1'b0;
                  integral_en  <= 1'b0;
                  hold_l       <= '0;
                  hold_m       <= '0;
                  hold_s       <= '0;
                  channel_lock <= 1'b0;
                  channel_sat  <= 1'b0;
                  if (mode == MODE_PD) begin
                     dco_pd_state     <= 1'b1;
                     tdc_pd_state     <= 1'b1;
                     tdc_pd_inj_state <= 1'b1;
                  end
                  if (mode == MODE_RX || mode == MODE_TX) begin
                     state <= ST_POWER_UP;
                  end
               end
               ST_POWER_UP: begin
                  time_count   <= time_count + 9'd1;
                  dco_pd_state <= 1'b0;
                  if (time_count == 9'(`ADPLL_PU_TDC)) begin
                     tdc_pd_state <= 1'b0;
                  end
                  if (time_count == 9'(`ADPLL_PU_INJ)) begin
                     tdc_pd_inj_state <= 1'b0;
                  end
                  if (time_count == 9'(`ADPLL_PU_DONE)) begin
                     state      <= ST_COARSE;
                     acc_clear  <= 1'b1;
                     time_count <= '0;
                  end
               end
               ST_COARSE: begin
                  acc_clear  <= 1'b0;
                  lock_clear <= 1'b0;
                  lock_en    <= 1'b1;
                  if (lock_seen) begin
                     hold_l     <= l_word_t'(lock_word);
                     state      <= ST_MEDIUM;
                     acc_clear  <= 1'b1;
                     lock_clear <= 1'b1;
                  end
               end
               ST_MEDIUM: begin
                  acc_clear  <= 1'b0;
                  lock_clear <= 1'b0;
                  if (lock_seen) begin
                     hold_m     <= ms_word_t'(lock_word);
                     state      <= ST_FINE;
                     acc_clear  <= 1'b1;
                     lock_clear <= 1'b1;
                     lock_en    <= 1'b0;
                  end
               end
               ST_FINE: begin
                  acc_clear   <= 1'b0;
                  integral_en <= (beta != 4'd0);
                  if (!channel_lock) begin
                     time_count <= time_count + 9'd1;
                  end
                  if (time_count == 9'(`ADPLL_LOCK_TIME - 1)) begin
                     channel_lock <= 1'b1;
                     hold_s       <= ms_word_t'(otw_sat);
                  end
                  // Fine word pinned at a rail means the channel is out of range
                  channel_sat <= (otw_sat == otw_t'(`ADPLL_MS_MAX)) ||
                                 (otw_sat == otw_t'(`ADPLL_MS_MIN));
               end
               default: state <= ST_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/adpll_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adpll_config.svh"

module adpll_ctrl import adpll_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   en,
   input  logic [`ADPLL_FCWW-1:0] fcw,
   input  adpll_mode_t            adpll_mode,
   input  logic [`ADPLL_TDCW-1:0] tdc_word,
   input  logic [3:0]             alpha_l,
   input  logic [3:0]             alpha_m,
   input  logic [3:0]             alpha_s_rx,
   input  logic [3:0]             alpha_s_tx,
   input  logic [3:0]             beta,
   input  logic [2:0]             lambda_rx,
   input  logic [2:0]             lambda_tx,
   input  logic [1:0]             iir_n_rx,
   input  logic [1:0]             iir_n_tx,
   input  l_word_t                dco_c_l_word_test,
   input  ms_word_t               dco_c_m_word_test,
   input  ms_word_t               dco_c_s_word_test,
   input  logic                   dco_pd_test,
   input  logic                   tdc_pd_test,
   input  logic                   tdc_pd_inj_test,
   output logic                   channel_lock,
   output logic                   channel_sat,
   output logic                   dco_pd,
   output logic                   tdc_pd,
   output logic                   tdc_pd_inj,
   output l_word_t                dco_c_l_word,
   output ms_word_t               dco_c_m_word,
   output ms_word_t               dco_c_s_word
);

   acq_state_t state;
   phase_t     ph_acc;
   phase_t     ntw;
   otw_t       otw_sat;
   otw_t       lock_word;
   l_word_t    hold_l;
   ms_word_t   hold_m;
   ms_word_t   hold_s;
   logic       acc_clear;
   logic       lock_clear;
   logic       lock_en;
   logic       coarse;
   logic       lock;
   logic [3:0] alpha;
   logic [2:0] lambda;
   logic [1:0] iir_n;
   logic       integral_en;
   logic       dco_pd_state;
   logic       tdc_pd_state;
   logic       tdc_pd_inj_state;

   ////////////////////////////////////////
   // Loop datapath
   ////////////////////////////////////////
   phase_accumulator u_phase_acc (
      .clk(clk), .rst(rst), .en(en),
      .fcw(fcw), .tdc_word(tdc_word), .acc_clear(acc_clear), .ph_acc(ph_acc)
   );

   loop_filter u_loop_filter (
      .clk(clk), .rst(rst), .en(en), .acc_clear(acc_clear), .ph_acc(ph_acc),
      .alpha(alpha), .beta(beta), .lambda(lambda), .iir_n(iir_n),
      .integral_en(integral_en), .ntw(ntw)
   );

   dco_word_steering u_steering (
      .ntw(ntw), .state(state), .mode(adpll_mode), .acc_clear(acc_clear),
      .hold_l(hold_l), .hold_m(hold_m), .hold_s(hold_s),
      .test_l(dco_c_l_word_test), .test_m(dco_c_m_word_test), .test_s(dco_c_s_word_test),
      .otw_sat(otw_sat), .dco_c_l_word(dco_c_l_word),
      .dco_c_m_word(dco_c_m_word), .dco_c_s_word(dco_c_s_word)
   );

   lock_detector u_lock_det (
      .clk(clk), .rst(rst), .en(en), .lock_clear(lock_clear), .lock_en(lock_en),
      .coarse(coarse), .otw_sat(otw_sat), .lock(lock), .lock_word(lock_word)
   );

   ////////////////////////////////////////
   // Sequencing
   ////////////////////////////////////////
   acquisition_fsm u_fsm (
      .clk(clk), .rst(rst), .en(en), .fcw(fcw), .mode(adpll_mode),
      .lock(lock), .lock_word(lock_word), .otw_sat(otw_sat),
      .alpha_l(alpha_l), .alpha_m(alpha_m), .alpha_s_rx(alpha_s_rx),
      .alpha_s_tx(alpha_s_tx), .beta(beta), .lambda_rx(lambda_rx),
      .lambda_tx(lambda_tx), .iir_n_rx(iir_n_rx), .iir_n_tx(iir_n_tx),
      .state(state), .acc_clear(acc_clear), .lock_clear(lock_clear),
      .lock_en(lock_en), .coarse(coarse), .alpha(alpha), .lambda(lambda),
      .iir_n(iir_n), .integral_en(integral_en),
      .hold_l(hold_l), .hold_m(hold_m), .hold_s(hold_s),
      .dco_pd_state(dco_pd_state), .tdc_pd_state(tdc_pd_state),
      .tdc_pd_inj_state(tdc_pd_inj_state),
      .channel_lock(channel_lock), .channel_sat(channel_sat)
   );

   // Test mode hands the analog power-downs to the pins
   assign dco_pd     = (adpll_mode == MODE_TEST) ? dco_pd_test : dco_pd_state;
   assign tdc_pd     = (adpll_mode == MODE_TEST) ? tdc_pd_test : tdc_pd_state;
   assign tdc_pd_inj = (adpll_mode == MODE_TEST) ? tdc_pd_inj_test : tdc_pd_inj_state;

endmodule

`default_nettype wire

// ==== src/adpll_pkg.sv ====
`default_nettype none

package adpll_pkg;

`include "adpll_config.svh"

   // Operating mode as driven by the radio
   typedef enum logic [1:0] {
      MODE_PD,
      MODE_TEST,
      MODE_RX,
      MODE_TX
   } adpll_mode_t;

   // Acquisition steps, one per capacitor bank
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_POWER_UP,
      ST_COARSE,
      ST_MEDIUM,
      ST_FINE
   } acq_state_t;

   typedef logic signed [`ADPLL_ACCW-1:0] phase_t;
   typedef logic signed [`ADPLL_OTWW-1:0] otw_t;
   typedef logic signed [4:0] l_word_t;
   typedef logic signed [7:0] ms_word_t;

endpackage

`default_nettype wire

// ==== src/dco_word_steering.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adpll_config.svh"

module dco_word_steering import adpll_pkg::*; (
   input  phase_t      ntw,
   input  acq_state_t  state,
   input  adpll_mode_t mode,
   input  logic        acc_clear,
   input  l_word_t     hold_l,
   input  ms_word_t    hold_m,
   input  ms_word_t    hold_s,
   input  l_word_t     test_l,
   input  ms_word_t    test_m,
   input  ms_word_t    test_s,
   output otw_t        otw_sat,
   output l_word_t     dco_c_l_word,
   output ms_word_t    dco_c_m_word,
   output ms_word_t    dco_c_s_word
);

   phase_t otw_scaled;
   otw_t   otw_int;
   otw_t   otw_round;
   otw_t   sat_max;
   otw_t   sat_min;

   // DCO gain normalization
   assign otw_scaled = ntw <<< `ADPLL_OTW_SHIFT;
   assign otw_int    = otw_scaled[`ADPLL_ACCW-1:`ADPLL_FRAW];
   assign otw_round  = otw_scaled[`ADPLL_FRAW-1] ? otw_int + otw_t'(1) : otw_int;

   // Large bank is narrower than medium and small
   always_comb begin
      if (state == ST_COARSE) begin
         sat_max = otw_t'(`ADPLL_L_MAX);
         sat_min = otw_t'(`ADPLL_L_MIN);
      end else begin
         sat_max = otw_t'(`ADPLL_MS_MAX);
         sat_min = otw_t'(`ADPLL_MS_MIN);
      end
      if (otw_round > sat_max) begin
         otw_sat = sat_max;
      end else if (otw_round < sat_min) begin
         otw_sat = sat_min;
      end else begin
         otw_sat = otw_round;
      end
   end

   ////////////////////////////////////////
   // Bank output select
   ////////////////////////////////////////
   always_comb begin
      dco_c_l_word = hold_l;
      dco_c_m_word = hold_m;
      dco_c_s_word = hold_s;
      if (mode == MODE_TEST) begin
         dco_c_l_word = test_l;
         dco_c_m_word = test_m;
         dco_c_s_word = test_s;
      end else if (!acc_clear) begin
         case (state)
            ST_COARSE: dco_c_l_word = l_word_t'(otw_sat);
            ST_MEDIUM: dco_c_m_word = ms_word_t'(otw_sat);
            ST_FINE:   dco_c_s_word = ms_word_t'(otw_sat);
            default:   ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/lock_detector.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adpll_config.svh"

module lock_detector import adpll_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic en,
   input  logic lock_clear,
   input  logic lock_en,
   input  logic coarse,
   input  otw_t otw_sat,
   output logic lock,
   output otw_t lock_word
);

   otw_t       cand_a;
   otw_t       cand_b;
   logic [3:0] cnt_a;
   logic [3:0] cnt_b;
   logic [3:0] repeat_thr;

   // Coarse bank settles in fewer steps
   assign repeat_thr = coarse ? 4'(`ADPLL_LOCK_REPEAT_COARSE) : 4'(`ADPLL_LOCK_REPEAT);

   always_ff @(posedge clk) begin
      if (rst || (en && lock_clear)) begin
         cand_a    <= '1;
         cand_b    <= '1;
         cnt_a     <= '0;
         cnt_b     <= '0;
         lock      <= 1'b0;
         lock_word <= '1;
      end else if (en && lock_en) begin
         if (otw_sat == cand_a) begin
            cnt_a <= cnt_a + 4'd1;
            if (!lock && (cnt_a + 4'd1 >= repeat_thr)) begin
               lock      <= 1'b1;
               lock_word <= cand_a;
            end
         end else if (otw_sat == cand_b) begin
            cnt_b <= cnt_b + 4'd1;
            if (!lock && (cnt_b + 4'd1 >= repeat_thr)) begin
               lock      <= 1'b1;
               lock_word <= cand_b;
            end
         end else begin
            // Word dithers between two values near lock, so keep both
            cand_b <= cand_a;
            cnt_b  <= cnt_a;
            cand_a <= otw_sat;
            cnt_a  <= 4'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/loop_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module loop_filter import adpll_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       en,
   input  logic       acc_clear,
   input  phase_t     ph_acc,
   input  logic [3:0] alpha,
   input  logic [3:0] beta,
   input  logic [2:0] lambda,
   input  logic [1:0] iir_n,
   input  logic       integral_en,
   output phase_t     ntw
);

   phase_t iir_out_1;
   phase_t iir_out_2;
   phase_t iir_out_3;
   phase_t iir_last_1;
   phase_t iir_last_2;
   phase_t iir_last_3;
   phase_t iir_sel;
   phase_t integral;
   phase_t integral_last;

   // First-order low pass, y += (x - y) * 2^-sh
   function automatic phase_t iir_step(input phase_t x, input phase_t y,
                                       input logic [2:0] sh);
      return (x >>> sh) - (y >>> sh) + y;
   endfunction

   ////////////////////////////////////////
   // IIR cascade
   ////////////////////////////////////////
   assign iir_out_1 = iir_step(ph_acc, iir_last_1, lambda);
   assign iir_out_2 = iir_step(iir_out_1, iir_last_2, lambda);
   assign iir_out_3 = iir_step(iir_out_2, iir_last_3, lambda);

   always_comb begin
      case (iir_n)
         2'd0:    iir_sel = ph_acc;
         2'd1:    iir_sel = iir_out_1;
         2'd2:    iir_sel = iir_out_2;
         default: iir_sel = iir_out_3;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         iir_last_1 <= '0;
         iir_last_2 <= '0;
         iir_last_3 <= '0;
      end else if (en) begin
         if (acc_clear) begin
            iir_last_1 <= '0;
            iir_last_2 <= '0;
            iir_last_3 <= '0;
         end else begin
            iir_last_1 <= iir_out_1;
            iir_last_2 <= iir_out_2;
            iir_last_3 <= iir_out_3;
         end
      end
   end

   ////////////////////////////////////////
   // Proportional and integral paths
   ////////////////////////////////////////
   assign integral = iir_sel + integral_last;

   // A clear restarts the sum from the present filter output
   always_ff @(posedge clk) begin
      if (rst) begin
         integral_last <= '0;
      end else if (en) begin
         integral_last <= acc_clear ? iir_sel : integral;
      end
   end

   assign ntw = integral_en ? (integral >>> beta) + (iir_sel >>> alpha)
                            : (iir_sel >>> alpha);

endmodule

`default_nettype wire

// ==== src/phase_accumulator.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adpll_config.svh"

module phase_accumulator import adpll_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   en,
   input  logic [`ADPLL_FCWW-1:0] fcw,
   input  logic [`ADPLL_TDCW-1:0] tdc_word,
   input  logic                   acc_clear,
   output phase_t                 ph_acc
);

   logic [`ADPLL_INTW-1:0]      fcw_int;
   logic [`ADPLL_FRAW-1:0]      fcw_frac;
   logic signed [`ADPLL_INTW:0] int_err;
   phase_t                      ph_err;

   assign {fcw_int, fcw_frac} = fcw;

   // TDC only resolves whole periods, so the fraction passes straight on
   assign int_err = $signed({1'b0, fcw_int}) - $signed({1'b0, tdc_word});
   assign ph_err  = {int_err, fcw_frac};

   always_ff @(posedge clk) begin
      if (rst) begin
         ph_acc <= '0;
      end else if (en) begin
         if (acc_clear) begin
            ph_acc <= '0;
         end else begin
            ph_acc <= ph_acc + ph_err;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_adpll_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adpll_config.svh"

module tb_adpll_ctrl import adpll_pkg::*; ();

   // Three acquisitions of about 650 cycles; room for five of 700
   localparam int TIMEOUT_CYCLES = 6000;
   localparam int LOCK_WAIT      = 1000;

   // Integer part one above, one below and half below the TDC word
   localparam logic [`ADPLL_FCWW-1:0] FCW_ABOVE      = {12'd101, 14'h0123};
   localparam logic [`ADPLL_FCWW-1:0] FCW_BELOW      = {12'd99, 14'h0123};
   localparam logic [`ADPLL_FCWW-1:0] FCW_HALF_BELOW = {12'd99, 14'h2000};
   localparam logic [`ADPLL_TDCW-1:0] TDC_FIXED      = 12'd100;

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   en;
   logic [`ADPLL_FCWW-1:0] fcw;
   adpll_mode_t            adpll_mode;
   logic [`ADPLL_TDCW-1:0] tdc_word;
   logic [3:0]             alpha_l;
   logic [3:0]             alpha_m;
   logic [3:0]             alpha_s_rx;
   logic [3:0]             alpha_s_tx;
   logic [3:0]             beta;
   logic [2:0]             lambda_rx;
   logic [2:0]             lambda_tx;
   logic [1:0]             iir_n_rx;
   logic [1:0]             iir_n_tx;
   l_word_t                dco_c_l_word_test;
   ms_word_t               dco_c_m_word_test;
   ms_word_t               dco_c_s_word_test;
   logic                   dco_pd_test;
   logic                   tdc_pd_test;
   logic                   tdc_pd_inj_test;
   logic                   channel_lock;
   logic                   channel_sat;
   logic                   dco_pd;
   logic                   tdc_pd;
   logic                   tdc_pd_inj;
   l_word_t                dco_c_l_word;
   ms_word_t               dco_c_m_word;
   ms_word_t               dco_c_s_word;

   integer seed = 32'hdfab_94d1;
   int     errors = 0;
   int     checks = 0;
   int     cycle_count = 0;

   adpll_ctrl u_dut (
      .clk(clk), .rst(rst), .en(en), .fcw(fcw), .adpll_mode(adpll_mode),
      .tdc_word(tdc_word), .alpha_l(alpha_l), .alpha_m(alpha_m),
      .alpha_s_rx(alpha_s_rx), .alpha_s_tx(alpha_s_tx), .beta(beta),
      .lambda_rx(lambda_rx), .lambda_tx(lambda_tx),
      .iir_n_rx(iir_n_rx), .iir_n_tx(iir_n_tx),
      .dco_c_l_word_test(dco_c_l_word_test), .dco_c_m_word_test(dco_c_m_word_test),
      .dco_c_s_word_test(dco_c_s_word_test), .dco_pd_test(dco_pd_test),
      .tdc_pd_test(tdc_pd_test), .tdc_pd_inj_test(tdc_pd_inj_test),
      .channel_lock(channel_lock), .channel_sat(channel_sat), .dco_pd(dco_pd),
      .tdc_pd(tdc_pd), .tdc_pd_inj(tdc_pd_inj), .dco_c_l_word(dco_c_l_word),
      .dco_c_m_word(dco_c_m_word), .dco_c_s_word(dco_c_s_word)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still going after %0d cycles", cycle_count);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic signed [31:0] actual,
                              input logic signed [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      end
   endtask

   task automatic check_banks(input int l_exp, input int m_exp, input int s_exp);
      check_value("dco_c_l_word", 32'(dco_c_l_word), l_exp);
      check_value("dco_c_m_word", 32'(dco_c_m_word), m_exp);
      check_value("dco_c_s_word", 32'(dco_c_s_word), s_exp);
   endtask

   // Inputs move just after the rising edge
   task automatic wait_drive_slot();
      @(posedge clk);
      #1;
   endtask

   function automatic logic pd_line(input int line_sel);
      case (line_sel)
         0:       return dco_pd;
         1:       return tdc_pd;
         default: return tdc_pd_inj;
      endcase
   endfunction

   task automatic cycles_until_low(input int line_sel, input int limit, output int cycles);
      cycles = 0;
      while (pd_line(line_sel) !== 1'b0 && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (pd_line(line_sel) !== 1'b0) begin
         errors++;
         $display("Error at %0t ns: power-down line %0d still high after %0d cycles",
                  $time, line_sel, limit);
      end
   endtask

   task automatic wait_for_lock(input int limit);
      int cycles;
      cycles = 0;
      while (channel_lock !== 1'b1 && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (channel_lock !== 1'b1) begin
         errors++;
         $display("Error at %0t ns: channel_lock did not rise within %0d cycles", $time, limit);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////
   task automatic reset_and_power_down();
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      repeat (4) @(negedge clk);
      check_value("dco_pd", 32'(dco_pd), 1);
      check_value("tdc_pd", 32'(tdc_pd), 1);
      check_value("tdc_pd_inj", 32'(tdc_pd_inj), 1);
      check_banks(0, 0, 0);
      check_value("channel_lock", 32'(channel_lock), 0);
      check_value("channel_sat", 32'(channel_sat), 0);
   endtask

   task automatic test_override();
      logic [2:0] pd_bits;
      repeat (4) begin
         wait_drive_slot();
         adpll_mode        = MODE_TEST;
         dco_c_l_word_test = l_word_t'($random(seed));
         dco_c_m_word_test = ms_word_t'($random(seed));
         dco_c_s_word_test = ms_word_t'($random(seed));
         pd_bits           = 3'($random(seed));
         dco_pd_test       = pd_bits[0];
         tdc_pd_test       = pd_bits[1];
         tdc_pd_inj_test   = pd_bits[2];
         @(negedge clk);
         check_banks(32'(dco_c_l_word_test), 32'(dco_c_m_word_test),
                     32'(dco_c_s_word_test));
         check_value("dco_pd", 32'(dco_pd), 32'(pd_bits[0]));
         check_value("tdc_pd", 32'(tdc_pd), 32'(pd_bits[1]));
         check_value("tdc_pd_inj", 32'(tdc_pd_inj), 32'(pd_bits[2]));
      end
   endtask

   task automatic power_up_order();
      int cycles;
      wait_drive_slot();
      fcw        = FCW_ABOVE;
      tdc_word   = TDC_FIXED;
      adpll_mode = MODE_RX;
      @(negedge clk);
      check_value("dco_pd", 32'(dco_pd), 1);
      cycles_until_low(0, 20, cycles);
      check_value("tdc_pd", 32'(tdc_pd), 1);
      cycles_until_low(1, 40, cycles);
      check_value("dco_pd to tdc_pd cycles", cycles, `ADPLL_PU_TDC);
      cycles_until_low(2, 60, cycles);
      check_value("tdc_pd to tdc_pd_inj cycles", cycles, `ADPLL_PU_INJ - `ADPLL_PU_TDC);
   endtask

   // Error only grows, so every bank ends on its upper rail
   task automatic positive_saturation_rx();
      wait_for_lock(LOCK_WAIT);
      @(negedge clk);
      check_banks(`ADPLL_L_MAX, `ADPLL_MS_MAX, `ADPLL_MS_MAX);
      check_value("channel_sat", 32'(channel_sat), 1);
      check_value("channel_lock", 32'(channel_lock), 1);
   endtask

   task automatic negative_saturation_tx();
      wait_drive_slot();
      fcw        = FCW_BELOW;
      adpll_mode = MODE_TX;
      repeat (3) @(negedge clk);
      check_value("channel_lock", 32'(channel_lock), 0);
      wait_for_lock(LOCK_WAIT);
      @(negedge clk);
      check_banks(`ADPLL_L_MIN, `ADPLL_MS_MIN, `ADPLL_MS_MIN);
      check_value("channel_sat", 32'(channel_sat), 1);
      check_value("channel_lock", 32'(channel_lock), 1);
   endtask

   task automatic restart_on_fcw_change();
      wait_drive_slot();
      fcw = FCW_HALF_BELOW;
      repeat (3) @(negedge clk);
      check_value("channel_lock", 32'(channel_lock), 0);
      check_value("channel_sat", 32'(channel_sat), 0);
      check_banks(0, 0, 0);
      // Slower ramp, still ends on the lower rails
      wait_for_lock(LOCK_WAIT);
      @(negedge clk);
      check_banks(`ADPLL_L_MIN, `ADPLL_MS_MIN, `ADPLL_MS_MIN);
      check_value("channel_lock", 32'(channel_lock), 1);
   endtask

   initial begin
      rst               = 1'b1;
      en                = 1'b1;
      fcw               = '0;
      adpll_mode        = MODE_PD;
      tdc_word          = '0;
      alpha_l           = 4'd4;
      alpha_m           = 4'd2;
      alpha_s_rx        = 4'd5;
      alpha_s_tx        = 4'd5;
      beta              = 4'd0;
      lambda_rx         = 3'd2;
      lambda_tx         = 3'd3;
      iir_n_rx          = 2'd1;
      iir_n_tx          = 2'd2;
      dco_c_l_word_test = '0;
      dco_c_m_word_test = '0;
      dco_c_s_word_test = '0;
      dco_pd_test       = 1'b0;
      tdc_pd_test       = 1'b0;
      tdc_pd_inj_test   = 1'b0;

      reset_and_power_down();
      test_override();
      power_up_order();
      positive_saturation_rx();
      negative_saturation_tx();
      restart_on_fcw_change();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
